// ==== Makefile ====
# Verilator simulation of the dual-initiator AHB-Lite subsystem

.PHONY: sim clean

sim:
	verilator --binary -f verilog.f --top-module tb_ahb_dual_init -Mdir obj_dir
	./obj_dir/Vtb_ahb_dual_init | tee /dev/stderr | grep "All checks passed"

clean:
	rm -rf obj_dir

// ==== sim/tb_ahb_init_tasks.svh ====
// AHB initiator port tasks

// Compares one value and stops at the first mismatch
task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
        $display("Checks failed");
        $fatal(1, "value mismatch in %s", name);
    end
endtask

// One NONSEQ transfer on one port, address phase then data phase
task automatic ahb_xfer(input int port, input bit write, input logic [31:0] addr,
                        input logic [2:0] size, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic resp);
    int cycles;
    int other;
    bit done;
    cycles = 0;
    other  = 1 - port;
    done   = 1'b0;
    @(posedge hclk);
    #1;
    req[port].hsel   = 1'b1;
    req[port].haddr  = addr;
    req[port].hwrite = write;
    req[port].htrans = ahb_pkg::NONSEQ;
    req[port].hsize  = ahb_pkg::hsize_e'(size);
    req[port].hready = rsp[port].hreadyout;
    @(posedge hclk);
    #1;
    // Data phase with the bus idle behind it
    req[port].hsel   = 1'b0;
    req[port].htrans = ahb_pkg::IDLE;
    req[port].hwdata = wdata;
    while (!done) begin
        @(negedge hclk);
        if (solo) begin
            check("idle_hreadyout", 32'd1, 32'(rsp[other].hreadyout));
            check("idle_hrdata", 32'd0, rsp[other].hrdata);
            check("idle_hresp", 32'd0, 32'(rsp[other].hresp));
        end
        if (rsp[port].hreadyout) begin
            rdata = rsp[port].hrdata;
            resp  = rsp[port].hresp;
            done  = 1'b1;
        end else begin
            cycles++;
            if (cycles > 100) begin
                $display("Initiator %0d data phase never completed", port);
                $display("Checks failed");
                $fatal(1, "hreadyout stuck low on initiator %0d", port);
            end
        end
    end
    done_time[port] = $time;
    @(posedge hclk);
endtask

// ==== sim/tb_ahb_dual_init.sv ====
// Dual-initiator AHB-Lite testbench

`timescale 1ns/100ps

module tb_ahb_dual_init;

    localparam int          WIN_BYTES = 4096;
    localparam logic [31:0] SEED      = 32'h103b_bf07;
    localparam int          N_STIM    = 22;

    typedef struct {
        string       name;
        int          port;
        bit          wr;
        logic [31:0] addr;
        logic [2:0]  size;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        resp;
        bit          conc;
    } entry_t;

    logic              hclk;
    logic              hreset_n;
    ahb_pkg::ahb_req_t req [2];
    ahb_pkg::ahb_rsp_t rsp [2];

    logic [31:0] model [WIN_BYTES/4];
    entry_t      stim [N_STIM];
    time         done_time [2];
    bit          solo;

    `include "tb_ahb_init_tasks.svh"

    ahb_dual_init_subsys #(
        .WAIT_STATES (1)
    ) u_dut (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .init0_req_i (req[0]),
        .init1_req_i (req[1]),
        .init0_rsp_o (rsp[0]),
        .init1_rsp_o (rsp[1])
    );

    initial begin
        hclk = 1'b0;
        forever #4 hclk = ~hclk;
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic logic [3:0] lane_mask(input logic [1:0] a, input logic [2:0] size);
        case (size)
            3'd0:    return 4'b0001 << a;
            3'd1:    return a[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic model_step(input entry_t e, input logic [31:0] rd, input logic rs);
        logic [3:0] mask;
        logic [9:0] idx;
        mask = lane_mask(e.addr[1:0], e.size);
        idx  = e.addr[11:2];
        if (e.addr < WIN_BYTES) begin
            check({e.name, "_resp"}, 32'd0, 32'(rs));
            if (e.wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) model[idx][8*b +: 8] = e.wdata[8*b +: 8];
                end
            end else begin
                check({e.name, "_model"}, model[idx], rd);
            end
        end else begin
            // Unmapped access returns ERROR and no data
            check({e.name, "_resp"}, 32'd1, 32'(rs));
            if (!e.wr) check({e.name, "_rdata"}, 32'd0, rd);
        end
    endtask

    // e0 is always port 0 when two entries run together
    task automatic do_entries(input entry_t e0, input entry_t e1, input bit conc,
                              output logic [31:0] rd0, output logic [31:0] rd1,
                              output logic rs0, output logic rs1);
        solo = !conc;
        if (conc) begin
            fork
                ahb_xfer(0, e0.wr, e0.addr, e0.size, e0.wdata, rd0, rs0);
                ahb_xfer(1, e1.wr, e1.addr, e1.size, e1.wdata, rd1, rs1);
            join
            check({e0.name, "_order"}, 32'd1, 32'(done_time[0] < done_time[1]));
            model_step(e0, rd0, rs0);
            model_step(e1, rd1, rs1);
        end else begin
            ahb_xfer(e0.port, e0.wr, e0.addr, e0.size, e0.wdata, rd0, rs0);
            model_step(e0, rd0, rs0);
        end
    endtask

    task automatic expect_entry(input entry_t e, input logic [31:0] rd, input logic rs);
        check({e.name, "_hresp"}, 32'(e.resp), 32'(rs));
        if (!e.wr) check({e.name, "_hrdata"}, e.rdata, rd);
    endtask

    function automatic entry_t rand_entry(input int port, input int n);
        entry_t e;
        e.name  = $sformatf("rnd%0d_p%0d", n, port);
        e.port  = port;
        e.wr    = ($urandom % 2) == 1;
        e.size  = 3'($urandom % 3);
        if (($urandom % 4) == 0) begin
            e.addr = 32'h1000 + ($urandom % 32'h0010_0000);
        end else begin
            e.addr = $urandom % 256;
        end
        e.addr  = e.addr & ~((32'd1 << e.size) - 32'd1);
        e.wdata = $urandom;
        e.rdata = '0;
        e.resp  = 1'b0;
        e.conc  = 1'b0;
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        entry_t      e0;
        entry_t      e1;
        logic [31:0] rd0;
        logic [31:0] rd1;
        logic        rs0;
        logic        rs1;
        int          i;
        int          n;
        bit          conc;

        void'($urandom(SEED));
        solo      = 1'b0;
        req[0]    = '0;
        req[1]    = '0;
        hreset_n  = 1'b0;

        stim[0]  = '{"p0_wr_a", 0, 1'b1, 32'h100, 3'd2, 32'h1111_2222, 32'h0, 1'b0, 1'b0};
        stim[1]  = '{"p0_wr_b", 0, 1'b1, 32'h104, 3'd2, 32'hdead_beef, 32'h0, 1'b0, 1'b0};
        stim[2]  = '{"p0_rd_a", 0, 1'b0, 32'h100, 3'd2, 32'h0, 32'h1111_2222, 1'b0, 1'b0};
        stim[3]  = '{"p0_rd_b", 0, 1'b0, 32'h104, 3'd2, 32'h0, 32'hdead_beef, 1'b0, 1'b0};
        stim[4]  = '{"p1_wr_a", 1, 1'b1, 32'h200, 3'd2, 32'hcafe_f00d, 32'h0, 1'b0, 1'b0};
        stim[5]  = '{"p1_wr_b", 1, 1'b1, 32'h3fc, 3'd2, 32'h0bad_c0de, 32'h0, 1'b0, 1'b0};
        stim[6]  = '{"p1_rd_a", 1, 1'b0, 32'h200, 3'd2, 32'h0, 32'hcafe_f00d, 1'b0, 1'b0};
        stim[7]  = '{"p1_rd_b", 1, 1'b0, 32'h3fc, 3'd2, 32'h0, 32'h0bad_c0de, 1'b0, 1'b0};
        stim[8]  = '{"both_wr0", 0, 1'b1, 32'h300, 3'd2, 32'haaaa_5555, 32'h0, 1'b0, 1'b1};
        stim[9]  = '{"both_wr1", 1, 1'b1, 32'h304, 3'd2, 32'h5555_aaaa, 32'h0, 1'b0, 1'b0};
        stim[10] = '{"both_rd0", 1, 1'b0, 32'h300, 3'd2, 32'h0, 32'haaaa_5555, 1'b0, 1'b0};
        stim[11] = '{"both_rd1", 0, 1'b0, 32'h304, 3'd2, 32'h0, 32'h5555_aaaa, 1'b0, 1'b0};
        stim[12] = '{"sram_p0", 0, 1'b0, 32'h104, 3'd2, 32'h0, 32'hdead_beef, 1'b0, 1'b1};
        stim[13] = '{"err_p1", 1, 1'b0, 32'h1000, 3'd2, 32'h0, 32'h0, 1'b1, 1'b0};
        stim[14] = '{"err_p0_wr", 0, 1'b1, 32'h8000_0000, 3'd2, 32'h7777_7777, 32'h0, 1'b1, 1'b1};
        stim[15] = '{"sram_p1_wr", 1, 1'b1, 32'h108, 3'd2, 32'h0102_0304, 32'h0, 1'b0, 1'b0};
        stim[16] = '{"rd_108", 0, 1'b0, 32'h108, 3'd2, 32'h0, 32'h0102_0304, 1'b0, 1'b0};
        stim[17] = '{"merge_word", 0, 1'b1, 32'h10c, 3'd2, 32'h0, 32'h0, 1'b0, 1'b0};
        stim[18] = '{"merge_b1", 1, 1'b1, 32'h10d, 3'd0, 32'h0000_ab00, 32'h0, 1'b0, 1'b0};
        stim[19] = '{"merge_h1", 0, 1'b1, 32'h10e, 3'd1, 32'h1234_0000, 32'h0, 1'b0, 1'b0};
        stim[20] = '{"merge_b0", 1, 1'b1, 32'h10c, 3'd0, 32'h0000_00cd, 32'h0, 1'b0, 1'b0};
        stim[21] = '{"merge_rd", 0, 1'b0, 32'h10c, 3'd2, 32'h0, 32'h1234_abcd, 1'b0, 1'b0};

        repeat (4) @(posedge hclk);
        #1;
        hreset_n = 1'b1;
        @(negedge hclk);
        check("rst_hreadyout0", 32'd1, 32'(rsp[0].hreadyout));
        check("rst_hreadyout1", 32'd1, 32'(rsp[1].hreadyout));
        check("rst_hresp", 32'd0, 32'({rsp[0].hresp, rsp[1].hresp}));

        // Preload the window used by the random traffic
        for (int w = 0; w < 64; w++) begin
            e0       = rand_entry(0, w);
            e0.name  = $sformatf("fill%0d", w);
            e0.wr    = 1'b1;
            e0.size  = 3'd2;
            e0.addr  = 32'(w * 4);
            e0.wdata = e0.addr * 32'h9e37_79b9 + 32'h6a09_e667;
            do_entries(e0, e0, 1'b0, rd0, rd1, rs0, rs1);
        end

        i = 0;
        while (i < N_STIM) begin
            conc = stim[i].conc;
            do_entries(stim[i], stim[conc ? i + 1 : i], conc, rd0, rd1, rs0, rs1);
            expect_entry(stim[i], rd0, rs0);
            if (conc) expect_entry(stim[i + 1], rd1, rs1);
            i += conc ? 2 : 1;
        end

        n = 0;
        while (n < 200) begin
            conc = ($urandom % 2) == 1;
            e0   = rand_entry(0, n);
            e1   = rand_entry(1, n);
            if (conc) begin
                do_entries(e0, e1, 1'b1, rd0, rd1, rs0, rs1);
                n += 2;
            end else begin
                do_entries((($urandom % 2) == 1) ? e1 : e0, e0, 1'b0, rd0, rd1, rs0, rs1);
                n += 1;
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== source/ahb_addr_decoder.sv ====
// AHB-Lite address decoder with default responder

`timescale 1ns/100ps

module ahb_addr_decoder (
    input  logic              hclk,
    input  logic              hreset_n,

    // From the mux
    input  ahb_pkg::ahb_req_t req_i,
    output ahb_pkg::ahb_rsp_t rsp_o,

    // SRAM responder
    output ahb_pkg::ahb_req_t sram_req_o,
    input  ahb_pkg::ahb_rsp_t sram_rsp_i
);

    // Two-cycle ERROR sequence of the default responder
    typedef enum logic [1:0] {
        ERR_IDLE   = 2'b00,
        ERR_FIRST  = 2'b01,
        ERR_SECOND = 2'b10
    } err_state_e;

    logic [ahb_pkg::ADDR_W-1:0] offset;
    logic                       accept;
    mem_map_pkg::region_e       region_a;
    mem_map_pkg::region_e       region_q;
    err_state_e                 err_q;
    err_state_e                 err_d;

    // ----------------------------------------------------------------------
    // Address phase decode
    // ----------------------------------------------------------------------
    assign offset   = req_i.haddr - mem_map_pkg::SRAM_BASE;
    assign region_a = (offset < mem_map_pkg::SRAM_BYTES) ? mem_map_pkg::REGION_SRAM
                                                         : mem_map_pkg::REGION_NONE;

    assign accept = req_i.hsel & req_i.hready &
                    (req_i.htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ});

    // Unmapped transfers never select the SRAM
    always_comb begin
        sram_req_o      = req_i;
        sram_req_o.hsel = req_i.hsel & (region_a == mem_map_pkg::REGION_SRAM);
    end

    // ----------------------------------------------------------------------
    // Data phase state
    // ----------------------------------------------------------------------
    always_comb begin
        case (err_q)
            ERR_FIRST: err_d = ERR_SECOND;
            default: begin
                err_d = (accept && region_a == mem_map_pkg::REGION_NONE) ? ERR_FIRST
                                                                         : ERR_IDLE;
            end
        endcase
    end

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            err_q    <= ERR_IDLE;
            region_q <= mem_map_pkg::REGION_SRAM;
        end else begin
            err_q <= err_d;
            // Idle cycles route back to the SRAM, which then shows ready
            if (req_i.hready) begin
                region_q <= accept ? region_a : mem_map_pkg::REGION_SRAM;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Response mux
    // ----------------------------------------------------------------------
    always_comb begin
        if (region_q == mem_map_pkg::REGION_NONE) begin
            rsp_o.hresp     = 1'b1;
            rsp_o.hreadyout = (err_q == ERR_SECOND);
            rsp_o.hrdata    = '0;
        end else begin
            rsp_o = sram_rsp_i;
        end
    end

endmodule

// ==== source/ahb_dual_init_subsys.sv ====
// Dual-initiator AHB-Lite subsystem top

`timescale 1ns/100ps

module ahb_dual_init_subsys #(
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic              hclk,
    input  logic              hreset_n,

    input  ahb_pkg::ahb_req_t init0_req_i,
    input  ahb_pkg::ahb_req_t init1_req_i,
    output ahb_pkg::ahb_rsp_t init0_rsp_o,
    output ahb_pkg::ahb_rsp_t init1_rsp_o
);

    ahb_pkg::ahb_req_t mux_req;
    ahb_pkg::ahb_rsp_t mux_rsp;
    ahb_pkg::ahb_req_t sram_req;
    ahb_pkg::ahb_rsp_t sram_rsp;

    ahb_lite_2to1_mux u_mux (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .init0_req_i (init0_req_i),
        .init0_rsp_o (init0_rsp_o),
        .init1_req_i (init1_req_i),
        .init1_rsp_o (init1_rsp_o),
        .tgt_req_o   (mux_req),
        .tgt_rsp_i   (mux_rsp)
    );

    ahb_addr_decoder u_decoder (
        .hclk       (hclk),
        .hreset_n   (hreset_n),
        .req_i      (mux_req),
        .rsp_o      (mux_rsp),
        .sram_req_o (sram_req),
        .sram_rsp_i (sram_rsp)
    );

    ahb_sram_responder #(
        .WAIT_STATES (WAIT_STATES)
    ) u_sram (
        .hclk     (hclk),
        .hreset_n (hreset_n),
        .req_i    (sram_req),
        .rsp_o    (sram_rsp)
    );

endmodule

// ==== source/ahb_lite_2to1_mux.sv ====
// Fixed-priority AHB-Lite 2:1 mux

`timescale 1ns/100ps

module ahb_lite_2to1_mux (
    input  logic              hclk,
    input  logic              hreset_n,

    // Initiator 0, the high priority side
    input  ahb_pkg::ahb_req_t init0_req_i,
    output ahb_pkg::ahb_rsp_t init0_rsp_o,

    // Initiator 1
    input  ahb_pkg::ahb_req_t init1_req_i,
    output ahb_pkg::ahb_rsp_t init1_rsp_o,

    // Shared responder path
    output ahb_pkg::ahb_req_t tgt_req_o,
    input  ahb_pkg::ahb_rsp_t tgt_rsp_i
);

    // Both initiators are handled as a two-entry array
    ahb_pkg::ahb_req_t init_req [2];
    ahb_pkg::ahb_req_t pend_req [2];
    ahb_pkg::ahb_req_t live_req [2];
    ahb_pkg::ahb_rsp_t init_rsp [2];

    logic [1:0] addr_ph;
    logic [1:0] pend_q;
    logic [1:0] data_ph_q;
    logic [1:0] gnt;

    assign init_req[0] = init0_req_i;
    assign init_req[1] = init1_req_i;

    // ----------------------------------------------------------------------
    // Address phase detect and grant
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            addr_ph[i] = init_req[i].hsel & init_req[i].hready &
                         (init_req[i].htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ});
            // A captured address phase replaces the live bus lines
            live_req[i] = pend_q[i] ? pend_req[i] : init_req[i];
        end

        // Initiator 0 wins whenever it has something and the path is ready
        gnt[0] = (addr_ph[0] | pend_q[0]) & tgt_rsp_i.hreadyout;
        gnt[1] = (addr_ph[1] | pend_q[1]) & tgt_rsp_i.hreadyout & ~gnt[0];
    end

    // ----------------------------------------------------------------------
    // Pending and data-phase tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            pend_q    <= '0;
            data_ph_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // Loser keeps its request parked until granted
                pend_q[i]    <= (addr_ph[i] | pend_q[i]) & ~gnt[i];
                // Owner holds the data phase while the responder stalls
                data_ph_q[i] <= gnt[i] | (data_ph_q[i] & ~tgt_rsp_i.hreadyout);
            end
        end
    end

    // Address phase snapshot, taken only on a fresh request
    always_ff @(posedge hclk) begin
        for (int i = 0; i < 2; i++) begin
            if (addr_ph[i] && !pend_q[i]) begin
                pend_req[i] <= init_req[i];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Forward path to the responder
    // ----------------------------------------------------------------------
    always_comb begin
        tgt_req_o = gnt[1] ? live_req[1] : live_req[0];

        // No grant means no address phase reaches the responders
        tgt_req_o.hsel = |gnt;
        if (gnt == 2'b00) begin
            tgt_req_o.htrans = ahb_pkg::IDLE;
        end

        tgt_req_o.hready = tgt_rsp_i.hreadyout;

        // Write data follows the data-phase owner, not the new grant
        tgt_req_o.hwdata = data_ph_q[1] ? init_req[1].hwdata : init_req[0].hwdata;
    end

    // ----------------------------------------------------------------------
    // Response routing
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            init_rsp[i].hresp  = data_ph_q[i] & tgt_rsp_i.hresp;
            init_rsp[i].hrdata = data_ph_q[i] ? tgt_rsp_i.hrdata : '0;

            // Stall a parked initiator, idle ones see ready
            if (pend_q[i]) begin
                init_rsp[i].hreadyout = 1'b0;
            end else if (data_ph_q[i]) begin
                init_rsp[i].hreadyout = tgt_rsp_i.hreadyout;
            end else begin
                init_rsp[i].hreadyout = 1'b1;
            end
        end
    end

    assign init0_rsp_o = init_rsp[0];
    assign init1_rsp_o = init_rsp[1];

endmodule

// ==== source/ahb_pkg.sv ====
// AHB-Lite bus types

package ahb_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // ----------------------------------------------------------------------
    // Transfer codes
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Only the sizes that fit in one data beat
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // ----------------------------------------------------------------------
    // Request and response bundles
    // ----------------------------------------------------------------------
    // Driven by an initiator, or by the mux towards the responders
    typedef struct packed {
        logic              hsel;
        logic [ADDR_W-1:0] haddr;
        logic [DATA_W-1:0] hwdata;
        logic              hwrite;
        htrans_e           htrans;
        hsize_e            hsize;
        logic              hready;
    } ahb_req_t;

    // hreadyout doubles as HREADY on the initiator side
    typedef struct packed {
        logic              hresp;
        logic              hreadyout;
        logic [DATA_W-1:0] hrdata;
    } ahb_rsp_t;

endpackage

// ==== source/ahb_sram_responder.sv ====
// AHB-Lite SRAM responder

`timescale 1ns/100ps

module ahb_sram_responder #(
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic              hclk,
    input  logic              hreset_n,

    input  ahb_pkg::ahb_req_t req_i,
    output ahb_pkg::ahb_rsp_t rsp_o
);

    localparam int         DEPTH    = mem_map_pkg::SRAM_BYTES / 4;
    localparam int         IDX_W    = $clog2(DEPTH);
    localparam logic [1:0] WAIT_CNT = 2'(WAIT_STATES);

    logic [ahb_pkg::DATA_W-1:0] mem [DEPTH];

    logic [ahb_pkg::ADDR_W-1:0] offset;
    logic                       accept;
    logic                       last_cyc;
    logic [3:0]                 byte_en;

    // Data phase control
    logic       dphase_q;
    logic [1:0] wait_q;

    // Captured address phase
    logic               write_q;
    logic [IDX_W-1:0]   idx_q;
    logic [1:0]         lane_q;
    ahb_pkg::hsize_e    size_q;

    assign offset = req_i.haddr - mem_map_pkg::SRAM_BASE;
    assign accept = req_i.hsel & req_i.hready &
                    (req_i.htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ});

    // ----------------------------------------------------------------------
    // Address capture and wait-state counter
    // ----------------------------------------------------------------------
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            dphase_q <= 1'b0;
            wait_q   <= '0;
        end else if (accept) begin
            dphase_q <= 1'b1;
            wait_q   <= WAIT_CNT;
        end else if (dphase_q) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                dphase_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            write_q <= req_i.hwrite;
            idx_q   <= offset[IDX_W+1:2];
            lane_q  <= offset[1:0];
            size_q  <= req_i.hsize;
        end
    end

    assign last_cyc = dphase_q & (wait_q == 2'd0);

    // ----------------------------------------------------------------------
    // Byte lanes and storage
    // ----------------------------------------------------------------------
    always_comb begin
        case (size_q)
            ahb_pkg::BYTE: byte_en = 4'b0001 << lane_q;
            ahb_pkg::HALF: byte_en = lane_q[1] ? 4'b1100 : 4'b0011;
            default:       byte_en = 4'b1111;
        endcase
    end

    // hwdata is only valid here, on the closing data-phase cycle
    always_ff @(posedge hclk) begin
        if (last_cyc && write_q) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx_q][8*b +: 8] <= req_i.hwdata[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Response
    // ----------------------------------------------------------------------
    assign rsp_o.hresp     = 1'b0;
    assign rsp_o.hreadyout = ~dphase_q | (wait_q == 2'd0);
    // Full aligned word regardless of size
    assign rsp_o.hrdata    = (last_cyc && !write_q) ? mem[idx_q] : '0;

endmodule

// ==== source/mem_map_pkg.sv ====
// Subsystem address map

package mem_map_pkg;

    // ----------------------------------------------------------------------
    // SRAM window
    // ----------------------------------------------------------------------
    // Base must be aligned to the window size
    parameter logic [ahb_pkg::ADDR_W-1:0] SRAM_BASE  = 32'h0000_0000;
    parameter logic [ahb_pkg::ADDR_W-1:0] SRAM_BYTES = 32'd4096;

    // ----------------------------------------------------------------------
    // Decoded target of an access
    // ----------------------------------------------------------------------
    // REGION_NONE goes to the built-in error responder
    typedef enum logic {
        REGION_SRAM = 1'b0,
        REGION_NONE = 1'b1
    } region_e;

endpackage

// ==== verilog.f ====
+incdir+sim
source/ahb_pkg.sv
source/mem_map_pkg.sv
source/ahb_lite_2to1_mux.sv
source/ahb_addr_decoder.sv
source/ahb_sram_responder.sv
source/ahb_dual_init_subsys.sv
sim/tb_ahb_dual_init.sv
